// ==== common/opm_reg_defs.svh ====
`ifndef OPM_REG_DEFS_SVH
`define OPM_REG_DEFS_SVH

////////////////////
// host bus

`define OPM_DW          8       // data bus width
`define OPM_SYNC_LEN    2       // flops per input synchronizer

////////////////////
// frame layout

`define OPM_NCH         8       // channels
`define OPM_NSLOT       32      // slots per sample frame

////////////////////
// write busy timer

`define OPM_BUSY_LEN    5

// top three address bits of a low (global) register
`define OPM_LO_LIMIT    3'b000

`endif

// ==== common/opm_reg_pkg.sv ====
`default_nettype none

`include "opm_reg_defs.svh"

package opm_reg_pkg;

    // global register addresses
    typedef enum logic [7:0] {
        LA_NOISE  = 8'h0F,  // ne, nfrq
        LA_CLKA1  = 8'h10,  // timer a upper bits
        LA_CLKA2  = 8'h11,  // timer a lower bits
        LA_CLKB   = 8'h12,
        LA_TCTRL  = 8'h14,  // run, irq enable, flag reset
        LA_LFRQ   = 8'h18,
        LA_PMDAMD = 8'h19,  // bit 7 picks pmd or amd
        LA_CT_W   = 8'h1B   // ct pins and lfo waveform
    } opm_loreg_addr_e;

    // address[7:3] of the per-channel groups
    typedef enum logic [4:0] {
        HG_RL_FL_ALG = 5'b00100,
        HG_KC        = 5'b00101,
        HG_KF        = 5'b00110,
        HG_PMS_AMS   = 5'b00111
    } opm_hireg_grp_e;

    typedef struct packed {
        logic [`OPM_DW-1:0] data;   // latched bus byte
        logic               addr_ld;
        logic               data_ld;
    } opm_bus_cmd_t;

    typedef struct packed {
        logic [7:0] clka1;
        logic [1:0] clka2;
        logic [7:0] clkb;
        logic       run_a;
        logic       run_b;
        logic       irq_en_a;
        logic       irq_en_b;
        logic       frst_a;         // one-cycle pulses
        logic       frst_b;
    } opm_timer_ctrl_t;

    typedef struct packed {
        logic [7:0] lfrq;
        logic [6:0] pmd;
        logic [6:0] amd;
        logic [1:0] w;
        logic       lfrq_update;
    } opm_lfo_ctrl_t;

    typedef struct packed {
        logic       ne;
        logic [4:0] nfrq;
        logic       ct1;
        logic       ct2;
    } opm_misc_ctrl_t;

    typedef struct packed {
        logic [6:0] kc;
        logic [5:0] kf;
        logic [2:0] pms;
        logic [1:0] ams;
        logic [1:0] rl;
        logic [2:0] fl;
        logic [2:0] alg;
    } opm_chan_fields_t;

    typedef struct packed {
        logic busy;
        logic timera_flag;
        logic timerb_flag;
    } opm_status_t;

endpackage

`default_nettype wire

// ==== design/opm_bus_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "opm_reg_defs.svh"

module opm_bus_sync
    import opm_reg_pkg::*;
(
    input  wire                 i_EMUCLK,
    input  wire                 mrst_n,
    input  wire                 i_cs_n,
    input  wire                 i_wr_n,
    input  wire                 i_a0,
    input  wire [`OPM_DW-1:0]   i_d,
    output opm_bus_cmd_t        o_cmd
);

////////////////////
// input synchronizers

logic [`OPM_SYNC_LEN-1:0]   cs_n_sync;  // bit 0 is the first stage
logic [`OPM_SYNC_LEN-1:0]   wr_n_sync;
logic [`OPM_SYNC_LEN-1:0]   a0_sync;
logic [`OPM_DW-1:0]         d_sync [`OPM_SYNC_LEN];

always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        cs_n_sync <= '1;    // bus idle
        wr_n_sync <= '1;
        a0_sync   <= '0;
    end else begin
        cs_n_sync <= {cs_n_sync[`OPM_SYNC_LEN-2:0], i_cs_n};
        wr_n_sync <= {wr_n_sync[`OPM_SYNC_LEN-2:0], i_wr_n};
        a0_sync   <= {a0_sync[`OPM_SYNC_LEN-2:0], i_a0};
    end
end

always_ff @(posedge i_EMUCLK) begin
    d_sync[0] <= i_d;
    for (int i = 1; i < `OPM_SYNC_LEN; i++) begin
        d_sync[i] <= d_sync[i-1];
    end
end

logic wr_strobe;
logic a0_s;

assign wr_strobe = ~cs_n_sync[`OPM_SYNC_LEN-1] & ~wr_n_sync[`OPM_SYNC_LEN-1];
assign a0_s      = a0_sync[`OPM_SYNC_LEN-1];

// bus latch, open while the strobe is low
logic [`OPM_DW-1:0] bus_latch;

always_ff @(posedge i_EMUCLK) begin
    if (wr_strobe) begin
        bus_latch <= d_sync[`OPM_SYNC_LEN-1];
    end
end

////////////////////
// request flags and load chains, [0] address and [1] data

logic [1:0] rq_set;
logic [1:0] rq_flag;
logic [1:0] ld_s0;
logic [1:0] ld_s1;
logic [1:0] ld_s2;

assign rq_set[0] = wr_strobe & ~a0_s & ~ld_s1[0];
assign rq_set[1] = wr_strobe &  a0_s & ~ld_s1[1];

always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        rq_flag <= '0;
        ld_s0   <= '0;
        ld_s1   <= '0;
        ld_s2   <= '0;
    end else begin
        rq_flag <= rq_set | (rq_flag & ~ld_s1);  // second stage clears the flag
        ld_s0   <= rq_flag;
        ld_s1   <= ld_s0;
        ld_s2   <= ld_s0 & ~ld_s1;  // leading edge only, one pulse per write
    end
end

assign o_cmd = '{data: bus_latch, addr_ld: ld_s2[0], data_ld: ld_s2[1]};

endmodule

`default_nettype wire

// ==== design/opm_status_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "opm_reg_defs.svh"

module opm_status_port
    import opm_reg_pkg::*;
(
    input  wire                 i_EMUCLK,
    input  wire                 mrst_n,
    input  wire opm_bus_cmd_t   i_cmd,
    input  wire                 i_cs_n,
    input  wire                 i_rd_n,
    input  wire                 i_a0,
    input  wire                 i_timera_flag,
    input  wire                 i_timerb_flag,
    output logic [`OPM_DW-1:0]  o_d,
    output logic                o_d_oe
);

////////////////////
// write busy timer

logic                       busy;
logic [`OPM_BUSY_LEN-1:0]   busy_cnt;
logic                       busy_co;
opm_status_t                status;

assign busy_co = busy & (&busy_cnt);    // 32nd busy clock

always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        busy     <= 1'b0;
        busy_cnt <= '0;
    end else begin
        busy     <= (busy & ~busy_co) | i_cmd.data_ld;
        busy_cnt <= busy ? busy_cnt + 1'b1 : '0;
    end
end

// status byte
assign status = '{busy: busy, timera_flag: i_timera_flag, timerb_flag: i_timerb_flag};
assign o_d    = {status.busy, 5'b00000, status.timera_flag, status.timerb_flag};
assign o_d_oe = ~|{~mrst_n, i_a0, i_rd_n, i_cs_n};

endmodule

`default_nettype wire

// ==== loreg/opm_loreg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "opm_reg_defs.svh"

module opm_loreg_file
    import opm_reg_pkg::*;
(
    input  wire                 i_EMUCLK,
    input  wire                 mrst_n,
    input  wire opm_bus_cmd_t   i_cmd,
    output opm_timer_ctrl_t     o_timer,
    output opm_lfo_ctrl_t       o_lfo,
    output opm_misc_ctrl_t      o_misc
);

localparam opm_loreg_addr_e LO_ADDR [8] = '{
    LA_NOISE, LA_CLKA1, LA_CLKA2, LA_CLKB, LA_TCTRL, LA_LFRQ, LA_PMDAMD, LA_CT_W
};
localparam int NLO = $size(LO_ADDR);

logic [`OPM_DW-1:0] d;
logic [NLO-1:0]     armed;  // one decoder per address
logic [NLO-1:0]     reg_ld;
logic               ld_noise, ld_clka1, ld_clka2, ld_clkb;
logic               ld_tctrl, ld_lfrq, ld_pmdamd, ld_ct_w;

assign d = i_cmd.data;

////////////////////
// address decoders

always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        armed <= '0;
    end else if (i_cmd.addr_ld) begin
        for (int i = 0; i < NLO; i++) begin
            armed[i] <= (d == LO_ADDR[i]);  // any other address disarms
        end
    end
end

always_comb begin
    for (int i = 0; i < NLO; i++) begin
        reg_ld[i] = armed[i] & i_cmd.data_ld;
    end
end

assign {ld_ct_w, ld_pmdamd, ld_lfrq, ld_tctrl} = reg_ld[7:4];
assign {ld_clkb, ld_clka2, ld_clka1, ld_noise} = reg_ld[3:0];

////////////////////
// global control registers

always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        o_timer <= '0;
        o_lfo   <= '0;
        o_misc  <= '0;
    end else begin
        o_timer.frst_a    <= ld_tctrl & d[4];
        o_timer.frst_b    <= ld_tctrl & d[5];
        o_lfo.lfrq_update <= ld_lfrq;

        if (ld_noise) begin
            o_misc.ne   <= d[7];
            o_misc.nfrq <= d[4:0];
        end
        if (ld_clka1) o_timer.clka1 <= d;
        if (ld_clka2) o_timer.clka2 <= d[1:0];
        if (ld_clkb) o_timer.clkb <= d;
        if (ld_tctrl) begin
            o_timer.run_a    <= d[0];
            o_timer.run_b    <= d[1];
            o_timer.irq_en_a <= d[2];
            o_timer.irq_en_b <= d[3];
        end
        if (ld_lfrq) o_lfo.lfrq <= d;
        if (ld_pmdamd) begin
            if (d[7]) o_lfo.pmd <= d[6:0];  // pmd
            else o_lfo.amd <= d[6:0];
        end
        if (ld_ct_w) begin
            o_misc.ct2 <= d[7];
            o_misc.ct1 <= d[6];
            o_lfo.w    <= d[1:0];
        end
    end
end

endmodule

`default_nettype wire

// ==== hireg/opm_hireg_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "opm_reg_defs.svh"

module opm_hireg_stage
    import opm_reg_pkg::*;
(
    input  wire                 i_EMUCLK,
    input  wire                 mrst_n,
    input  wire opm_bus_cmd_t   i_cmd,
    input  wire                 i_cycle_31,
    output logic [3:0]          o_grp_we,   // one bit per group
    output logic [`OPM_DW-1:0]  o_hdata
);

localparam int CH_BITS   = $clog2(`OPM_NCH);
localparam int SLOT_BITS = $clog2(`OPM_NSLOT);
localparam opm_hireg_grp_e GRP_LIST [4] = '{HG_RL_FL_ALG, HG_KC, HG_KF, HG_PMS_AMS};

logic [`OPM_DW-1:0]     hi_addr;
logic [`OPM_DW-1:0]     hi_data;
logic                   addr_valid;
logic                   data_valid;
logic                   addr_en;
logic                   data_en;
logic [SLOT_BITS-1:0]   slot;

assign addr_en = i_cmd.addr_ld & (i_cmd.data[7:5] != `OPM_LO_LIMIT);
assign data_en = i_cmd.data_ld & addr_valid;

////////////////////
// temporary address/data registers

always_ff @(posedge i_EMUCLK) begin
    if (addr_en) hi_addr <= i_cmd.data;
    if (data_en) hi_data <= i_cmd.data;
end

always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        addr_valid <= 1'b0;
        data_valid <= 1'b0;
        slot       <= '0;
        o_grp_we   <= '0;
    end else begin
        // a low address write drops both flags
        addr_valid <= addr_en | (addr_valid & ~i_cmd.addr_ld);
        data_valid <= data_en | (data_valid & ~i_cmd.addr_ld);

        slot <= i_cycle_31 ? '0 : slot + 1'b1;

        // channel match, lands one slot later
        for (int g = 0; g < 4; g++) begin
            o_grp_we[g] <= addr_valid & data_valid
                         & (hi_addr[7:3] == GRP_LIST[g])
                         & (hi_addr[CH_BITS-1:0] == slot[CH_BITS-1:0]);
        end
    end
end

assign o_hdata = hi_data;

endmodule

`default_nettype wire

// ==== hireg/opm_chan_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "opm_reg_defs.svh"

module opm_chan_regs
    import opm_reg_pkg::*;
(
    input  wire                 i_EMUCLK,
    input  wire                 mrst_n,
    input  wire [3:0]           i_grp_we,
    input  wire [`OPM_DW-1:0]   i_hdata,
    output opm_chan_fields_t    o_chan
);

// write enable bit of each group
localparam int WE_RL_FL_ALG = HG_RL_FL_ALG - HG_RL_FL_ALG;
localparam int WE_KC        = HG_KC - HG_RL_FL_ALG;
localparam int WE_KF        = HG_KF - HG_RL_FL_ALG;
localparam int WE_PMS_AMS   = HG_PMS_AMS - HG_RL_FL_ALG;

// stage 0 trails the slot counter by two, so stage n-2 is current
localparam int TAP = `OPM_NCH - 2;

opm_chan_fields_t sr [`OPM_NCH];
opm_chan_fields_t sr_in;

always_comb begin
    sr_in = sr[`OPM_NCH-1];     // recirculate
    if (i_grp_we[WE_RL_FL_ALG]) begin
        sr_in.rl  = i_hdata[7:6];
        sr_in.fl  = i_hdata[5:3];
        sr_in.alg = i_hdata[2:0];
    end
    if (i_grp_we[WE_KC]) sr_in.kc = i_hdata[6:0];
    if (i_grp_we[WE_KF]) sr_in.kf = i_hdata[7:2];
    if (i_grp_we[WE_PMS_AMS]) begin
        sr_in.pms = i_hdata[6:4];
        sr_in.ams = i_hdata[1:0];
    end
end

always_ff @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) begin
        for (int k = 0; k < `OPM_NCH; k++) begin
            sr[k] <= '0;
        end
    end else begin
        sr[0] <= sr_in;
        for (int k = 1; k < `OPM_NCH; k++) begin
            sr[k] <= sr[k-1];
        end
    end
end

assign o_chan = sr[TAP];

endmodule

`default_nettype wire

// ==== design/opm_reg_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "opm_reg_defs.svh"

module opm_reg_top
    import opm_reg_pkg::*;
(
    input  wire                 i_EMUCLK,
    input  wire                 mrst_n,
    // host bus
    input  wire                 i_cs_n,
    input  wire                 i_wr_n,
    input  wire                 i_rd_n,
    input  wire                 i_a0,
    input  wire [`OPM_DW-1:0]   i_d,
    // timing and timer flags
    input  wire                 i_cycle_31,
    input  wire                 i_timera_flag,
    input  wire                 i_timerb_flag,
    output logic [`OPM_DW-1:0]  o_d,
    output logic                o_d_oe,
    // register outputs
    output opm_timer_ctrl_t     o_timer,
    output opm_lfo_ctrl_t       o_lfo,
    output opm_misc_ctrl_t      o_misc,
    output opm_chan_fields_t    o_chan
);

opm_bus_cmd_t       cmd;
logic [3:0]         grp_we;
logic [`OPM_DW-1:0] hdata;

////////////////////
// bus side

opm_bus_sync u_bus_sync (
    .i_EMUCLK (i_EMUCLK),
    .mrst_n   (mrst_n),
    .i_cs_n   (i_cs_n),
    .i_wr_n   (i_wr_n),
    .i_a0     (i_a0),
    .i_d      (i_d),
    .o_cmd    (cmd)
);

opm_status_port u_status_port (
    .i_EMUCLK      (i_EMUCLK),
    .mrst_n        (mrst_n),
    .i_cmd         (cmd),
    .i_cs_n        (i_cs_n),
    .i_rd_n        (i_rd_n),
    .i_a0          (i_a0),
    .i_timera_flag (i_timera_flag),
    .i_timerb_flag (i_timerb_flag),
    .o_d           (o_d),
    .o_d_oe        (o_d_oe)
);

////////////////////
// register blocks

opm_loreg_file u_loreg_file (
    .i_EMUCLK (i_EMUCLK),
    .mrst_n   (mrst_n),
    .i_cmd    (cmd),
    .o_timer  (o_timer),
    .o_lfo    (o_lfo),
    .o_misc   (o_misc)
);

opm_hireg_stage u_hireg_stage (
    .i_EMUCLK   (i_EMUCLK),
    .mrst_n     (mrst_n),
    .i_cmd      (cmd),
    .i_cycle_31 (i_cycle_31),
    .o_grp_we   (grp_we),
    .o_hdata    (hdata)
);

opm_chan_regs u_chan_regs (
    .i_EMUCLK (i_EMUCLK),
    .mrst_n   (mrst_n),
    .i_grp_we (grp_we),
    .i_hdata  (hdata),
    .o_chan   (o_chan)
);

endmodule

`default_nettype wire

// ==== bench/tb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic o_clk,
    output logic o_mrst_n
);

initial begin
    o_clk = 1'b0;
    forever #10 o_clk = ~o_clk;     // 20 ns period
end

// reset held for 8 cycles
initial begin
    o_mrst_n = 1'b0;
    repeat (8) @(posedge o_clk);
    #2 o_mrst_n = 1'b1;
end

endmodule

`default_nettype wire

// ==== bench/opm_reg_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module opm_reg_checker
    import opm_reg_pkg::*;
(
    input  wire                 i_EMUCLK,
    input  wire                 mrst_n,
    input  wire                 i_cs_n,
    input  wire                 i_rd_n,
    input  wire                 i_a0,
    input  wire                 i_cycle_31,
    input  wire                 i_timera_flag,
    input  wire                 i_timerb_flag,
    // dut outputs
    input  wire [7:0]           i_d,
    input  wire                 i_d_oe,
    input  opm_timer_ctrl_t     i_timer,
    input  opm_lfo_ctrl_t       i_lfo,
    input  opm_misc_ctrl_t      i_misc,
    input  opm_chan_fields_t    i_chan,
    // expected values from the reference model
    input  opm_timer_ctrl_t     i_exp_timer,
    input  opm_lfo_ctrl_t       i_exp_lfo,
    input  opm_misc_ctrl_t      i_exp_misc,
    input  opm_chan_fields_t [7:0] i_exp_chan,
    input  wire                 i_exp_busy,
    input  int                  i_exp_frst_a,
    input  int                  i_exp_frst_b,
    input  int                  i_exp_lfrq_upd,
    // check windows and test boundaries
    input  wire                 i_lo_chk_en,
    input  wire                 i_chan_chk_en,
    input  wire                 i_test_done,
    input  int                  i_test_num,
    output int                  o_errors,
    output int                  o_tests,
    output int                  o_failed_tests
);

logic [4:0]         slot;
opm_timer_ctrl_t    timer_seen;
opm_lfo_ctrl_t      lfo_seen;
logic               oe_exp;
logic [7:0]         d_exp;
int                 n_frst_a;
int                 n_frst_b;
int                 n_lfrq_upd;
int                 errs_at_start;

// slot count as seen by the channel registers
always @(posedge i_EMUCLK or negedge mrst_n) begin
    if (!mrst_n) slot <= '0;
    else slot <= i_cycle_31 ? 5'd0 : slot + 5'd1;
end

// pulse bits are counted, not compared
always_comb begin
    timer_seen        = i_timer;
    timer_seen.frst_a = 1'b0;
    timer_seen.frst_b = 1'b0;
    lfo_seen             = i_lfo;
    lfo_seen.lfrq_update = 1'b0;
end

task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    o_errors++;
    $display("ERR t=%0t %s exp=%0h got=%0h", $time, name, exp, got);
endtask

initial begin
    o_errors       = 0;
    o_tests        = 0;
    o_failed_tests = 0;
    n_frst_a       = 0;
    n_frst_b       = 0;
    n_lfrq_upd     = 0;
    errs_at_start  = 0;
end

////////////////////
// compare on the falling edge

always @(negedge i_EMUCLK) begin
    if (mrst_n) begin
        oe_exp = ~i_cs_n & ~i_rd_n & ~i_a0;
        d_exp  = {i_exp_busy, 5'b00000, i_timera_flag, i_timerb_flag};
        if (i_d_oe !== oe_exp) report_value("o_d_oe", 32'(oe_exp), 32'(i_d_oe));
        if (i_d_oe && i_d !== d_exp) report_value("o_d", 32'(d_exp), 32'(i_d));

        if (i_timer.frst_a) n_frst_a++;
        if (i_timer.frst_b) n_frst_b++;
        if (i_lfo.lfrq_update) n_lfrq_upd++;

        if (i_lo_chk_en) begin
            if (timer_seen !== i_exp_timer)
                report_value("o_timer", 32'(i_exp_timer), 32'(timer_seen));
            if (lfo_seen !== i_exp_lfo) report_value("o_lfo", 32'(i_exp_lfo), 32'(lfo_seen));
            if (i_misc !== i_exp_misc) report_value("o_misc", 32'(i_exp_misc), 32'(i_misc));
        end
        if (i_chan_chk_en && i_chan !== i_exp_chan[slot[2:0]])
            report_value("o_chan", 32'(i_exp_chan[slot[2:0]]), 32'(i_chan));

        if (i_test_done) begin
            // pulse counts are cumulative over the run
            if (n_frst_a != i_exp_frst_a) report_value("frst_a count", i_exp_frst_a, n_frst_a);
            if (n_frst_b != i_exp_frst_b) report_value("frst_b count", i_exp_frst_b, n_frst_b);
            if (n_lfrq_upd != i_exp_lfrq_upd)
                report_value("lfrq_update count", i_exp_lfrq_upd, n_lfrq_upd);
            o_tests++;
            if (o_errors != errs_at_start) o_failed_tests++;
            $display("test %0d finished, %0d errors", i_test_num, o_errors - errs_at_start);
            errs_at_start = o_errors;
        end
    end
end

endmodule

`default_nettype wire

// ==== bench/tb_opm_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "opm_reg_defs.svh"

module tb_opm_reg
    import opm_reg_pkg::*;
();

// test lengths in clocks for the watchdog
localparam int LEN_T1 = 60;
localparam int LEN_T2 = 640;
localparam int LEN_T3 = 200;
localparam int LEN_T4 = 1560;
localparam int LEN_T5 = 200;
localparam longint WD_NS = 64'(LEN_T1 + LEN_T2 + LEN_T3 + LEN_T4 + LEN_T5) * 20 * 3 / 2;

logic clk, mrst_n;
logic cs_n, wr_n, rd_n, a0, cycle_31, ta_flag, tb_flag;
logic [7:0] d;
logic [7:0] o_d;
logic o_d_oe;
opm_timer_ctrl_t o_timer;
opm_lfo_ctrl_t o_lfo;
opm_misc_ctrl_t o_misc;
opm_chan_fields_t o_chan;

// reference model state
opm_timer_ctrl_t exp_timer;
opm_lfo_ctrl_t exp_lfo;
opm_misc_ctrl_t exp_misc;
opm_chan_fields_t [7:0] exp_chan;
logic exp_busy, lo_chk_en, chan_chk_en, test_done;
int exp_frst_a, exp_frst_b, exp_lfrq_upd, test_num;
int errors, tests, failed_tests;
logic [31:0] rng_state;
int cyc;

localparam logic [7:0] LO_LIST [8] = '{8'h0F, 8'h10, 8'h11, 8'h12, 8'h14, 8'h18, 8'h19, 8'h1B};

tb_clkgen u_clkgen (.o_clk(clk), .o_mrst_n(mrst_n));

opm_reg_top i_dut (
    .i_EMUCLK(clk), .mrst_n(mrst_n), .i_cs_n(cs_n), .i_wr_n(wr_n), .i_rd_n(rd_n),
    .i_a0(a0), .i_d(d), .i_cycle_31(cycle_31), .i_timera_flag(ta_flag),
    .i_timerb_flag(tb_flag), .o_d(o_d), .o_d_oe(o_d_oe), .o_timer(o_timer),
    .o_lfo(o_lfo), .o_misc(o_misc), .o_chan(o_chan)
);

opm_reg_checker u_checker (
    .i_EMUCLK(clk), .mrst_n(mrst_n), .i_cs_n(cs_n), .i_rd_n(rd_n), .i_a0(a0),
    .i_cycle_31(cycle_31), .i_timera_flag(ta_flag), .i_timerb_flag(tb_flag),
    .i_d(o_d), .i_d_oe(o_d_oe), .i_timer(o_timer), .i_lfo(o_lfo), .i_misc(o_misc),
    .i_chan(o_chan), .i_exp_timer(exp_timer), .i_exp_lfo(exp_lfo), .i_exp_misc(exp_misc),
    .i_exp_chan(exp_chan), .i_exp_busy(exp_busy), .i_exp_frst_a(exp_frst_a),
    .i_exp_frst_b(exp_frst_b), .i_exp_lfrq_upd(exp_lfrq_upd), .i_lo_chk_en(lo_chk_en),
    .i_chan_chk_en(chan_chk_en), .i_test_done(test_done), .i_test_num(test_num),
    .o_errors(errors), .o_tests(tests), .o_failed_tests(failed_tests)
);

function logic [7:0] rand_byte();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;   // lcg
    return rng_state[23:16];
endfunction

// register model updated once a data write has landed
function void opm_ref_expect(input logic [7:0] addr, input logic [7:0] data);
    logic [2:0] ch;
    ch = addr[2:0];
    if (addr[7:5] != `OPM_LO_LIMIT) begin
        case (addr[7:3])
            HG_RL_FL_ALG: begin
                exp_chan[ch].rl  = data[7:6];
                exp_chan[ch].fl  = data[5:3];
                exp_chan[ch].alg = data[2:0];
            end
            HG_KC: exp_chan[ch].kc = data[6:0];
            HG_KF: exp_chan[ch].kf = data[7:2];
            HG_PMS_AMS: begin
                exp_chan[ch].pms = data[6:4];
                exp_chan[ch].ams = data[1:0];
            end
            default: ;
        endcase
    end else begin
        case (addr)
            LA_NOISE: {exp_misc.ne, exp_misc.nfrq} = {data[7], data[4:0]};
            LA_CLKA1: exp_timer.clka1 = data;
            LA_CLKA2: exp_timer.clka2 = data[1:0];
            LA_CLKB: exp_timer.clkb = data;
            LA_TCTRL: begin
                {exp_timer.irq_en_b, exp_timer.irq_en_a} = data[3:2];
                {exp_timer.run_b, exp_timer.run_a} = data[1:0];
                if (data[4]) exp_frst_a++;
                if (data[5]) exp_frst_b++;
            end
            LA_LFRQ: begin
                exp_lfo.lfrq = data;
                exp_lfrq_upd++;
            end
            LA_PMDAMD: begin
                if (data[7]) exp_lfo.pmd = data[6:0];
                else exp_lfo.amd = data[6:0];
            end
            LA_CT_W: {exp_misc.ct2, exp_misc.ct1, exp_lfo.w} = {data[7:6], data[1:0]};
            default: ;
        endcase
    end
endfunction

////////////////////
// bus tasks

task automatic bus_write(input logic sel, input logic [7:0] data);
    @(posedge clk);
    #2 {cs_n, wr_n, a0, d} = {2'b00, sel, data};
    repeat (2) @(posedge clk);
    #2 {cs_n, wr_n} = 2'b11;
    repeat (12) @(posedge clk);     // bus idle time
endtask

task automatic bus_read(input logic sel);
    @(posedge clk);
    #2 {cs_n, rd_n, a0} = {2'b00, sel};
    repeat (2) @(posedge clk);
    #2 {cs_n, rd_n, a0} = 3'b110;
    repeat (2) @(posedge clk);
endtask

task automatic lo_data_write(input logic [7:0] addr, input logic [7:0] data);
    #2 lo_chk_en = 1'b0;
    bus_write(1'b1, data);
    repeat (4) @(posedge clk);
    #2 opm_ref_expect(addr, data);
    lo_chk_en = 1'b1;
endtask

task automatic hi_write(input logic [4:0] grp, input logic [2:0] ch, input logic [7:0] data);
    bus_write(1'b0, {grp, ch});
    #2 chan_chk_en = 1'b0;
    bus_write(1'b1, data);
    repeat (64) @(posedge clk);     // two frames
    #2 opm_ref_expect({grp, ch}, data);
    chan_chk_en = 1'b1;
    repeat (32) @(posedge clk);
endtask

task automatic end_test(input int n);
    @(posedge clk);
    #2 {test_num, test_done} = {n, 1'b1};
    @(posedge clk);
    #2 test_done = 1'b0;
endtask

// frame marker every 32 clocks
initial begin
    cyc = 0;
    forever begin
        @(posedge clk);
        #2 cycle_31 = (cyc == 31);
        cyc = (cyc + 1) % 32;
    end
end

initial begin
    #(WD_NS);
    $display("watchdog: run did not finish in time");
    $display("*** TEST FAILED ***");
    $finish;
end

initial begin
    logic [7:0] data;
    {cs_n, wr_n, rd_n, a0, d, cycle_31, ta_flag, tb_flag} = {3'b111, 1'b0, 8'h00, 3'b000};
    {exp_timer, exp_lfo, exp_misc, exp_chan} = '0;
    {exp_busy, lo_chk_en, chan_chk_en, test_done} = 4'b0000;
    {exp_frst_a, exp_frst_b, exp_lfrq_upd, test_num} = {32'd0, 32'd0, 32'd0, 32'd0};
    rng_state = 32'h61cb;
    @(posedge mrst_n);

    // test 1 checks the reset values
    repeat (2) @(posedge clk);
    #2 {lo_chk_en, chan_chk_en} = 2'b11;
    repeat (40) @(posedge clk);
    bus_read(1'b0);                 // busy low after reset
    end_test(1);

    // test 2 writes each low address three times
    for (int i = 0; i < 8; i++) begin
        bus_write(1'b0, LO_LIST[i]);
        for (int k = 0; k < 3; k++) begin
            data = rand_byte();
            if (LO_LIST[i] == LA_PMDAMD) data[7] = k[0];
            lo_data_write(LO_LIST[i], data);
        end
    end
    end_test(2);

    // test 3 counts flag-reset and lfo update pulses
    bus_write(1'b0, LA_TCTRL);
    lo_data_write(LA_TCTRL, 8'h10 | (rand_byte() & 8'h0F));
    lo_data_write(LA_TCTRL, 8'h20 | (rand_byte() & 8'h0F));
    lo_data_write(LA_TCTRL, 8'h30 | (rand_byte() & 8'h0F));
    lo_data_write(LA_TCTRL, rand_byte() & 8'h0F);
    bus_write(1'b0, LA_LFRQ);
    lo_data_write(LA_LFRQ, rand_byte());
    lo_data_write(LA_LFRQ, rand_byte());
    end_test(3);

    // test 4 writes every channel group three times
    for (int n = 0; n < 12; n++) begin
        data = rand_byte();
        hi_write({3'b001, n[1:0]}, data[2:0], rand_byte());
    end
    end_test(4);

    // test 5 reads the status byte
    #2 {ta_flag, tb_flag} = 2'b10;
    bus_read(1'b0);
    bus_write(1'b0, LA_CLKB);
    data = rand_byte();
    #2 lo_chk_en = 1'b0;
    bus_write(1'b1, data);
    #2 exp_busy = 1'b1;
    bus_read(1'b0);
    repeat (32) @(posedge clk);     // 48 clocks after the write
    #2 exp_busy = 1'b0;
    opm_ref_expect(LA_CLKB, data);
    lo_chk_en = 1'b1;
    {ta_flag, tb_flag} = 2'b01;
    bus_read(1'b0);
    bus_read(1'b1);                 // a0 high keeps the bus off
    end_test(5);

    repeat (4) @(posedge clk);
    $display("summary: %0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
    if (errors == 0 && failed_tests == 0) begin
        $display("*** TEST PASSED ***");
    end else begin
        $display("*** TEST FAILED ***");
    end
    $finish;
end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+common
common/opm_reg_pkg.sv
design/opm_bus_sync.sv
design/opm_status_port.sv
loreg/opm_loreg_file.sv
hireg/opm_hireg_stage.sv
hireg/opm_chan_regs.sv
design/opm_reg_top.sv
bench/tb_clkgen.sv
bench/opm_reg_checker.sv
bench/tb_opm_reg.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module tb_opm_reg \
    -f build.f -o tb_opm_reg_sim

./obj_dir/tb_opm_reg_sim > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    exit 1
fi
grep -qF "*** TEST PASSED ***" sim.log
